/* include/apb_reg_hub_defs.svh */
`ifndef APB_REG_HUB_DEFS_SVH
`define APB_REG_HUB_DEFS_SVH

// bus widths shared by APB and the register link
`define HUB_ADDR_WIDTH 16
`define HUB_DATA_WIDTH 32

// cycles spent waiting for ack before the transfer is failed
`define HUB_TIMEOUT_CYCLES 15

// words per on-chip register bank
`define HUB_BANK_WORDS 8

// address map, each window spans 2**HUB_WINDOW_BITS bytes
`define HUB_WINDOW_BITS 8
`define HUB_BANK0_BASE 16'h0000
`define HUB_BANK1_BASE 16'h0100
`define HUB_EXT_BASE 16'h0200

// read value seen by the master on a timed-out transfer
`define HUB_TIMEOUT_RDATA 32'hdead_1eaf

`endif

/* source/apb_reg_hub_pkg.sv */
`include "apb_reg_hub_defs.svh"

package apb_reg_hub_pkg;

    // request side of the register link
    typedef struct packed {
        // pending request, held until ack
        logic                       vld;
        // one-cycle cancel, together with the falling vld
        logic                       abort;
        logic                       write;
        logic [`HUB_ADDR_WIDTH-1:0] addr;
        logic [`HUB_DATA_WIDTH-1:0] wdata;
    } reg_req_t;

    // response side, ack is a single-cycle pulse
    typedef struct packed {
        logic                       ack;
        logic [`HUB_DATA_WIDTH-1:0] rdata;
    } reg_rsp_t;

    // leaf picked by the address decoder
    typedef enum logic [1:0] {
        LEAF_BANK0,
        LEAF_BANK1,
        LEAF_EXT,
        LEAF_NONE
    } leaf_sel_t;

endpackage

/* source/apb_req_fsm.sv */
`timescale 1ns/1ps
`include "apb_reg_hub_defs.svh"

module apb_req_fsm (
    input  logic                       PCLK,
    input  logic                       PRESETn,
    input  logic                       PSEL,
    input  logic                       PENABLE,
    input  logic                       PWRITE,
    input  logic [`HUB_ADDR_WIDTH-1:0] PADDR,
    input  logic [`HUB_DATA_WIDTH-1:0] PWDATA,
    output logic [`HUB_DATA_WIDTH-1:0] PRDATA,
    output logic                       PREADY,
    output logic                       PSLVERR,
    output apb_reg_hub_pkg::reg_req_t  req,
    input  apb_reg_hub_pkg::reg_rsp_t  rsp,
    input  logic                       irq_clear,
    output logic                       irq,
    output logic [`HUB_ADDR_WIDTH-1:0] fault_addr
);

    localparam int CNT_W = $clog2(`HUB_TIMEOUT_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        DONE
    } state_t;

    state_t                     state;
    logic [CNT_W-1:0]           wait_cnt;
    logic                       req_vld;
    logic                       req_abort;
    logic                       req_write;
    logic [`HUB_ADDR_WIDTH-1:0] req_addr;
    logic [`HUB_DATA_WIDTH-1:0] req_wdata;
    logic [`HUB_DATA_WIDTH-1:0] rdata_q;
    logic                       err_q;
    logic                       setup_seen;
    logic                       time_out;

    // setup phase of a new APB transfer
    assign setup_seen = PSEL && !PENABLE;

    // last wait cycle with no ack in sight
    assign time_out = (state == WAIT_ACK) && !rsp.ack &&
                      (wait_cnt == CNT_W'(`HUB_TIMEOUT_CYCLES - 1));

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state     <= IDLE;
            req_vld   <= 1'b0;
            req_abort <= 1'b0;
            wait_cnt  <= '0;
            err_q     <= 1'b0;
        end else begin
            // abort lives for one cycle only
            req_abort <= 1'b0;
            case (state)
                IDLE: begin
                    if (setup_seen) begin
                        state    <= WAIT_ACK;
                        req_vld  <= 1'b1;
                        wait_cnt <= '0;
                    end
                end
                WAIT_ACK: begin
                    if (rsp.ack) begin
                        state   <= DONE;
                        req_vld <= 1'b0;
                        err_q   <= 1'b0;
                    end else if (time_out) begin
                        state     <= DONE;
                        req_vld   <= 1'b0;
                        req_abort <= 1'b1;
                        err_q     <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload, latched at setup
    always_ff @(posedge PCLK) begin
        if (state == IDLE && setup_seen) begin
            req_write <= PWRITE;
            req_addr  <= PADDR;
            req_wdata <= PWDATA;
        end
    end

    // read data taken in the ack cycle
    always_ff @(posedge PCLK) begin
        if (state == WAIT_ACK && rsp.ack) begin
            rdata_q <= rsp.rdata;
        end
    end

    // sticky interrupt, a fresh timeout beats a clear
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            irq        <= 1'b0;
            fault_addr <= '0;
        end else if (time_out) begin
            irq        <= 1'b1;
            fault_addr <= req_addr;
        end else if (irq_clear) begin
            irq        <= 1'b0;
            fault_addr <= '0;
        end
    end

    assign req = '{vld: req_vld, abort: req_abort, write: req_write,
                   addr: req_addr, wdata: req_wdata};

    // APB completion, one cycle in DONE
    assign PREADY  = (state == DONE);
    assign PSLVERR = (state == DONE) && err_q;
    assign PRDATA  = err_q ? `HUB_TIMEOUT_RDATA : rdata_q;

endmodule

/* source/reg_leaf_decoder.sv */
`timescale 1ns/1ps
`include "apb_reg_hub_defs.svh"

module reg_leaf_decoder (
    input  apb_reg_hub_pkg::reg_req_t req,
    output apb_reg_hub_pkg::reg_rsp_t rsp,
    output apb_reg_hub_pkg::reg_req_t bank0_req,
    output apb_reg_hub_pkg::reg_req_t bank1_req,
    output apb_reg_hub_pkg::reg_req_t ext_req,
    input  apb_reg_hub_pkg::reg_rsp_t bank0_rsp,
    input  apb_reg_hub_pkg::reg_rsp_t bank1_rsp,
    input  apb_reg_hub_pkg::reg_rsp_t ext_rsp
);

    import apb_reg_hub_pkg::*;

    localparam int ADDR_W  = `HUB_ADDR_WIDTH;
    localparam int WIN_LSB = `HUB_WINDOW_BITS;

    localparam logic [ADDR_W-1:0] BANK0_BASE = `HUB_BANK0_BASE;
    localparam logic [ADDR_W-1:0] BANK1_BASE = `HUB_BANK1_BASE;
    localparam logic [ADDR_W-1:0] EXT_BASE   = `HUB_EXT_BASE;

    leaf_sel_t                 sel;
    logic [ADDR_W-1:WIN_LSB]   win;

    // only the selected leaf sees vld and abort
    function automatic reg_req_t route(input reg_req_t r, input logic hit);
        reg_req_t o;
        o       = r;
        o.vld   = r.vld && hit;
        o.abort = r.abort && hit;
        return o;
    endfunction

    assign win = req.addr[ADDR_W-1:WIN_LSB];

    always_comb begin
        if (win == BANK0_BASE[ADDR_W-1:WIN_LSB]) begin
            sel = LEAF_BANK0;
        end else if (win == BANK1_BASE[ADDR_W-1:WIN_LSB]) begin
            sel = LEAF_BANK1;
        end else if (win == EXT_BASE[ADDR_W-1:WIN_LSB]) begin
            sel = LEAF_EXT;
        end else begin
            sel = LEAF_NONE;
        end
    end

    assign bank0_req = route(req, sel == LEAF_BANK0);
    assign bank1_req = route(req, sel == LEAF_BANK1);
    assign ext_req   = route(req, sel == LEAF_EXT);

    // unmapped addresses never ack, the endpoint times out
    always_comb begin
        case (sel)
            LEAF_BANK0: rsp = bank0_rsp;
            LEAF_BANK1: rsp = bank1_rsp;
            LEAF_EXT:   rsp = ext_rsp;
            default:    rsp = '0;
        endcase
    end

endmodule

/* source/reg_bank.sv */
`timescale 1ns/1ps
`include "apb_reg_hub_defs.svh"

module reg_bank #(
    parameter int ACK_DELAY = 0
) (
    input  logic                      PCLK,
    input  logic                      PRESETn,
    input  apb_reg_hub_pkg::reg_req_t req,
    output apb_reg_hub_pkg::reg_rsp_t rsp
);

    localparam int IDX_W = $clog2(`HUB_BANK_WORDS);
    localparam int CNT_W = (ACK_DELAY > 0) ? $clog2(ACK_DELAY + 1) : 1;

    logic [`HUB_DATA_WIDTH-1:0] regs [`HUB_BANK_WORDS];
    logic [`HUB_DATA_WIDTH-1:0] rdata_q;
    logic [IDX_W-1:0]           idx;
    logic [CNT_W-1:0]           delay_cnt;
    logic                       busy;
    logic                       ack_q;
    logic                       start;
    logic                       fire;

    // word index from the byte offset
    assign idx = req.addr[IDX_W+1:2];

    // a new request, not the one still held through its ack cycle
    assign start = req.vld && !busy && !ack_q;
    assign fire  = (ACK_DELAY == 0) ? start : (busy && delay_cnt == '0);

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            busy      <= 1'b0;
            ack_q     <= 1'b0;
            delay_cnt <= '0;
        end else begin
            ack_q <= 1'b0;
            if (req.abort) begin
                // request dropped, nothing is answered
                busy      <= 1'b0;
                delay_cnt <= '0;
            end else if (fire) begin
                busy  <= 1'b0;
                ack_q <= 1'b1;
            end else if (start) begin
                busy      <= 1'b1;
                delay_cnt <= CNT_W'(ACK_DELAY - 1);
            end else if (busy) begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
    end

    // write lands together with the ack
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            for (int i = 0; i < `HUB_BANK_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (fire && !req.abort && req.write) begin
            regs[idx] <= req.wdata;
        end
    end

    always_ff @(posedge PCLK) begin
        if (fire && !req.write) begin
            rdata_q <= regs[idx];
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

/* source/apb_reg_hub.sv */
`timescale 1ns/1ps
`include "apb_reg_hub_defs.svh"

module apb_reg_hub (
    input  logic                       PCLK,
    input  logic                       PRESETn,
    input  logic                       PSEL,
    input  logic                       PENABLE,
    input  logic                       PWRITE,
    input  logic [`HUB_ADDR_WIDTH-1:0] PADDR,
    input  logic [`HUB_DATA_WIDTH-1:0] PWDATA,
    output logic [`HUB_DATA_WIDTH-1:0] PRDATA,
    output logic                       PREADY,
    output logic                       PSLVERR,
    output apb_reg_hub_pkg::reg_req_t  ext_req,
    input  apb_reg_hub_pkg::reg_rsp_t  ext_rsp,
    input  logic                       irq_clear,
    output logic                       irq,
    output logic [`HUB_ADDR_WIDTH-1:0] fault_addr
);

    import apb_reg_hub_pkg::*;

    reg_req_t hub_req;
    reg_rsp_t hub_rsp;
    reg_req_t bank0_req;
    reg_rsp_t bank0_rsp;
    reg_req_t bank1_req;
    reg_rsp_t bank1_rsp;

    apb_req_fsm i_apb_req_fsm (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .req        (hub_req),
        .rsp        (hub_rsp),
        .irq_clear  (irq_clear),
        .irq        (irq),
        .fault_addr (fault_addr)
    );

    reg_leaf_decoder i_reg_leaf_decoder (
        .req       (hub_req),
        .rsp       (hub_rsp),
        .bank0_req (bank0_req),
        .bank1_req (bank1_req),
        .ext_req   (ext_req),
        .bank0_rsp (bank0_rsp),
        .bank1_rsp (bank1_rsp),
        .ext_rsp   (ext_rsp)
    );

    // fast bank answers in the cycle after vld
    reg_bank #(.ACK_DELAY(0)) i_bank0 (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .req     (bank0_req),
        .rsp     (bank0_rsp)
    );

    reg_bank #(.ACK_DELAY(3)) i_bank1 (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .req     (bank1_req),
        .rsp     (bank1_rsp)
    );

endmodule

/* verification/apb_reg_hub_tb.sv */
`timescale 1ns/1ps
`include "apb_reg_hub_defs.svh"

module apb_reg_hub_tb;

    import apb_reg_hub_pkg::*;

    localparam int PERIOD          = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_RANDOM      = 40;
    localparam int CYCLES_PER_XFER = 40;

    localparam logic [15:0] BANK0_BASE = `HUB_BANK0_BASE;
    localparam logic [15:0] BANK1_BASE = `HUB_BANK1_BASE;
    localparam logic [15:0] EXT_BASE   = `HUB_EXT_BASE;

    // one line of the stimulus table
    typedef struct packed {
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic        mute;
        logic        clr;
        logic        err;
    } row_t;

    logic        PCLK      = 1'b0;
    logic        PRESETn   = 1'b0;
    logic        PSEL      = 1'b0;
    logic        PENABLE   = 1'b0;
    logic        PWRITE    = 1'b0;
    logic [15:0] PADDR     = '0;
    logic [31:0] PWDATA    = '0;
    logic        irq_clear = 1'b0;
    reg_rsp_t    ext_rsp   = '0;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    reg_req_t    ext_req;
    logic        irq;
    logic [15:0] fault_addr;

    row_t        rows[$];
    logic [31:0] ref_mem [256];
    logic [31:0] ext_mem [64];
    logic        ext_mute        = 1'b0;
    int          ext_wait        = 0;
    int          ext_ack_count   = 0;
    int          ext_abort_count = 0;
    logic        ext_seen_write;
    logic [15:0] ext_seen_addr;
    logic [31:0] ext_seen_wdata;
    logic        exp_irq   = 1'b0;
    logic [15:0] exp_fault = '0;
    integer      seed      = 32'hc707;

    apb_reg_hub i_apb_reg_hub (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .ext_req    (ext_req),
        .ext_rsp    (ext_rsp),
        .irq_clear  (irq_clear),
        .irq        (irq),
        .fault_addr (fault_addr)
    );

    always #(PERIOD / 2) PCLK = ~PCLK;

    // external slave, acks two cycles after vld unless muted
    always @(negedge PCLK) begin
        if (!PRESETn) begin
            for (int i = 0; i < 64; i++) begin
                ext_mem[i] = '0;
            end
            ext_rsp  = '0;
            ext_wait = 0;
        end else if (ext_rsp.ack) begin
            ext_rsp.ack = 1'b0;
            ext_wait    = 0;
        end else if (ext_req.abort) begin
            ext_abort_count++;
            ext_wait = 0;
        end else if (ext_req.vld && !ext_mute) begin
            ext_wait++;
            if (ext_wait == 2) begin
                ext_rsp.ack    = 1'b1;
                ext_seen_write = ext_req.write;
                ext_seen_addr  = ext_req.addr;
                ext_seen_wdata = ext_req.wdata;
                if (ext_req.write) begin
                    ext_mem[ext_req.addr[7:2]] = ext_req.wdata;
                end else begin
                    ext_rsp.rdata = ext_mem[ext_req.addr[7:2]];
                end
                ext_ack_count++;
            end
        end else begin
            ext_wait = 0;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic row_t make_row(input logic write, input logic [15:0] addr,
                                      input logic [31:0] wdata, input logic mute,
                                      input logic clr, input logic err);
        return '{write: write, addr: addr, wdata: wdata, mute: mute, clr: clr, err: err};
    endfunction

    // window decode by the address map
    function automatic leaf_sel_t leaf_of(input logic [15:0] addr);
        if (addr[15:8] == BANK0_BASE[15:8]) return LEAF_BANK0;
        if (addr[15:8] == BANK1_BASE[15:8]) return LEAF_BANK1;
        if (addr[15:8] == EXT_BASE[15:8]) return LEAF_EXT;
        return LEAF_NONE;
    endfunction

    // banks alias on bits 4:2, the external window holds 64 words
    function automatic logic [7:0] ref_index(input logic [15:0] addr);
        leaf_sel_t leaf;
        leaf = leaf_of(addr);
        if (leaf == LEAF_EXT) return {2'd2, addr[7:2]};
        return {leaf, 3'b000, addr[4:2]};
    endfunction

    task automatic apb_transfer(input logic write, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge PCLK);
        PENABLE = 1'b1;
        while (!PREADY) begin
            @(negedge PCLK);
        end
        rdata = PRDATA;
        err   = PSLVERR;
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic pulse_irq_clear();
        @(negedge PCLK);
        irq_clear = 1'b1;
        @(negedge PCLK);
        irq_clear = 1'b0;
        exp_irq   = 1'b0;
        exp_fault = '0;
        check_value("irq after clear", 32'(irq), 32'(exp_irq));
        check_value("fault_addr after clear", 32'(fault_addr), 32'(exp_fault));
    endtask

    task automatic run_access(input row_t r);
        logic [31:0] rdata;
        logic        err;
        int          acks_before;
        int          aborts_before;
        leaf_sel_t   leaf;
        logic [7:0]  idx;
        if (r.clr) begin
            pulse_irq_clear();
        end
        leaf          = leaf_of(r.addr);
        idx           = ref_index(r.addr);
        ext_mute      = r.mute;
        acks_before   = ext_ack_count;
        aborts_before = ext_abort_count;
        apb_transfer(r.write, r.addr, r.wdata, rdata, err);
        ext_mute = 1'b0;
        check_value("PSLVERR", 32'(err), 32'(r.err));
        if (r.err) begin
            check_value("timeout PRDATA", rdata, `HUB_TIMEOUT_RDATA);
            exp_irq   = 1'b1;
            exp_fault = r.addr;
            if (leaf == LEAF_EXT) begin
                check_value("ext abort pulses", ext_abort_count, aborts_before + 1);
            end
        end else if (r.write) begin
            ref_mem[idx] = r.wdata;
        end else begin
            check_value("read data", rdata, ref_mem[idx]);
        end
        // link request seen by the external slave
        if (!r.err && leaf == LEAF_EXT) begin
            check_value("ext acks", ext_ack_count, acks_before + 1);
            check_value("ext write flag", 32'(ext_seen_write), 32'(r.write));
            check_value("ext address", 32'(ext_seen_addr), 32'(r.addr));
            if (r.write) begin
                check_value("ext write data", ext_seen_wdata, r.wdata);
            end
        end
        check_value("irq", 32'(irq), 32'(exp_irq));
        check_value("fault_addr", 32'(fault_addr), 32'(exp_fault));
    endtask

    task automatic load_table();
        // bank0 writes, read back, one unwritten word
        rows.push_back(make_row(1'b1, 16'h0000, 32'h1111_1111, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b1, 16'h0004, 32'h2222_2222, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b1, 16'h001c, 32'ha5a5_a5a5, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0000, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0004, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h001c, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0008, 32'h0, 1'b0, 1'b0, 1'b0));
        // bank1 at the same offsets
        rows.push_back(make_row(1'b1, 16'h0100, 32'h3333_3333, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b1, 16'h0104, 32'h4444_4444, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0100, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0104, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0000, 32'h0, 1'b0, 1'b0, 1'b0));
        // external window
        rows.push_back(make_row(1'b1, 16'h0200, 32'h5555_5555, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b1, 16'h02fc, 32'h6666_6666, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0200, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h02fc, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0210, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0104, 32'h0, 1'b0, 1'b0, 1'b0));
        // timeouts, then irq held over good transfers until cleared
        rows.push_back(make_row(1'b0, 16'h0300, 32'h0, 1'b0, 1'b0, 1'b1));
        rows.push_back(make_row(1'b1, 16'h0200, 32'hbad0_0bad, 1'b1, 1'b0, 1'b1));
        rows.push_back(make_row(1'b0, 16'h0200, 32'h0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(1'b0, 16'h0004, 32'h0, 1'b0, 1'b1, 1'b0));
        rows.push_back(make_row(1'b1, 16'hf000, 32'h7777_7777, 1'b0, 1'b0, 1'b1));
        rows.push_back(make_row(1'b0, 16'h0208, 32'h0, 1'b1, 1'b0, 1'b1));
        rows.push_back(make_row(1'b0, 16'h0100, 32'h0, 1'b0, 1'b1, 1'b0));
    endtask

    initial begin
        row_t        r;
        logic [31:0] rv;
        logic [1:0]  win;
        load_table();
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge PCLK);
        PRESETn = 1'b1;
        check_value("PREADY after reset", 32'(PREADY), 32'h0);
        check_value("irq after reset", 32'(irq), 32'h0);
        check_value("fault_addr after reset", 32'(fault_addr), 32'h0);
        foreach (rows[i]) begin
            run_access(rows[i]);
        end
        // random mix over the three mapped windows
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rv  = $random(seed);
            win = rv[9:8];
            if (win == 2'd3) begin
                win = rv[10] ? 2'd1 : 2'd2;
            end
            r = make_row(rv[16], {6'd0, win, rv[7:2], 2'b00}, $random(seed),
                         1'b0, 1'b0, 1'b0);
            run_access(r);
        end
        $display("All tests passed!");
        $finish;
    end

    // watchdog sized from the number of transfers
    initial begin
        int limit;
        #1;
        limit = (rows.size() + NUM_RANDOM) * CYCLES_PER_XFER + 2 * RESET_CYCLES;
        repeat (limit) @(posedge PCLK);
        $display("Timeout: the APB transfers did not finish within %0d cycles", limit);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

/* apb_reg_hub.f */
+incdir+include
source/apb_reg_hub_pkg.sv
source/apb_req_fsm.sv
source/reg_leaf_decoder.sv
source/reg_bank.sv
source/apb_reg_hub.sv
verification/apb_reg_hub_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the APB register hub simulation with Verilator.
# The exit status is the simulator's own status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module apb_reg_hub_tb \
    -f apb_reg_hub.f \
    -Mdir obj_dir \
    -o apb_reg_hub_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/apb_reg_hub_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
fi
exit "$sim_status"
